//--- source/l2_cache_defines.svh
/*
  Geometry of the L2 data array.
  The array is four ways of 512 sets, each line four 128-bit words.
  L2_INDEX_W must stay equal to log2 of L2_SETS.
  L2_WAYS and L2_WORDS are assumed to be powers of two.
*/
`ifndef L2_CACHE_DEFINES_SVH
`define L2_CACHE_DEFINES_SVH

// number of ways in the array
`define L2_WAYS     4

// 128-bit words in one cache line
`define L2_WORDS    4

// sets held by each way
`define L2_SETS     512

`define L2_INDEX_W  9       // log2 of L2_SETS

`define L2_WORD_W   128     // bits per word

`endif

//--- source/l2_cache_pkg.sv
/*
  Shared types of the L2 data array.
  Word 0 of a line sits in the low bits.
  Field order in the request structs is MSB first as declared.
*/
`default_nettype none

`include "l2_cache_defines.svh"

package l2_cache_pkg;

    typedef logic [`L2_INDEX_W-1:0]        l2_index_t;     // set index
    typedef logic [`L2_WORD_W-1:0]         l2_word_t;      // one data word
    typedef l2_word_t [`L2_WORDS-1:0]      l2_line_t;      // full cache line
    typedef logic [`L2_WAYS-1:0]           way_mask_t;     // one bit per way
    typedef logic [$clog2(`L2_WAYS)-1:0]   way_num_t;      // encoded way
    typedef logic [$clog2(`L2_WORDS)-1:0]  word_sel_t;     // word offset in line

    typedef struct packed {
        l2_index_t  index;
        way_mask_t  way_we;         // ways allowed to take the write
        logic       fill_en;        // line fill from memory
        logic       l1_wr_en;       // single word write-back from L1
        word_sel_t  offset;         // word slot of the L1 write
        l2_line_t   fill_line;
        l2_word_t   l1_word;
    } l2_wr_req_t;

    typedef struct packed {
        logic       rd_en;
        l2_index_t  index;
        way_num_t   way;
        word_sel_t  offset;         // word returned on rd_word
    } l2_rd_req_t;

    typedef struct packed {
        l2_index_t             index;
        logic [`L2_WORDS-1:0]  word_we;    // per word write enable
        l2_line_t              line;
    } way_wr_t;

endpackage

`default_nettype wire

//--- source/l2_write_steer.sv
/*
  Write and read steering for the L2 data array.
  A fill beats an L1 write in the same cycle.
  An L1 word goes only to the lowest way whose way_we bit is set.
  Write commands and read enables are combinational.
  Way number and offset of a read come out one cycle later.
*/
`default_nettype none

`include "l2_cache_defines.svh"

module l2_write_steer (
    input  wire                                     clk,
    input  wire                                     rst_n,
    input  wire l2_cache_pkg::l2_wr_req_t           wr_req,
    input  wire l2_cache_pkg::l2_rd_req_t           rd_req,
    output l2_cache_pkg::way_wr_t [`L2_WAYS-1:0]    way_wr,
    output l2_cache_pkg::way_mask_t                 rd_way_en,
    output l2_cache_pkg::l2_index_t                 rd_index,
    output logic                                    rd_pending,
    output l2_cache_pkg::way_num_t                  rd_way_q,
    output l2_cache_pkg::word_sel_t                 rd_offset_q
);
    import l2_cache_pkg::*;

    way_mask_t             l1_way;         // lowest set way_we bit only
    logic [`L2_WORDS-1:0]  l1_word_we;     // one-hot word from offset
    l2_line_t              wr_line;

    // isolate the lowest set bit of the way mask
    assign l1_way = wr_req.way_we & (~wr_req.way_we + 1'b1);

    assign l1_word_we = {{(`L2_WORDS-1){1'b0}}, 1'b1} << wr_req.offset;

    // L1 word copied to every slot so the bank needs no merge
    assign wr_line = wr_req.fill_en ? wr_req.fill_line : {`L2_WORDS{wr_req.l1_word}};

    always_comb begin
        for (int w = 0; w < `L2_WAYS; w++) begin
            way_wr[w].index   = wr_req.index;
            way_wr[w].line    = wr_line;
            way_wr[w].word_we = '0;
            if (wr_req.fill_en) begin
                if (wr_req.way_we[w]) begin
                    way_wr[w].word_we = '1;     // whole line
                end
            end else if (wr_req.l1_wr_en && l1_way[w]) begin
                way_wr[w].word_we = l1_word_we;
            end
        end
    end

    // only the addressed bank reads
    always_comb begin
        rd_way_en = '0;
        if (rd_req.rd_en) begin
            rd_way_en[rd_req.way] = 1'b1;
        end
    end

    assign rd_index = rd_req.index;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_pending <= 1'b0;
        end else begin
            rd_pending <= rd_req.rd_en;    // lines up with bank q
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req.rd_en) begin
            rd_way_q    <= rd_req.way;
            rd_offset_q <= rd_req.offset;
        end
    end

endmodule

`default_nettype wire

//--- source/l2_data_way.sv
/*
  One way of the L2 data array, 512 lines of four 128-bit words.
  Each word column is its own RAM so one word can be written alone.
  Read is registered and q holds between reads.
  Same index read and write in one cycle returns the old data.
  Contents and q are not reset.
*/
`default_nettype none

`include "l2_cache_defines.svh"

module l2_data_way (
    input  wire                         clk,
    input  wire l2_cache_pkg::way_wr_t  wr,
    input  wire                         rd_en,
    input  wire l2_cache_pkg::l2_index_t rd_index,
    output l2_cache_pkg::l2_line_t      q
);
    import l2_cache_pkg::*;

    for (genvar w = 0; w < `L2_WORDS; w++) begin : g_word
        l2_word_t mem [`L2_SETS];          // one 512x128 word column

        always_ff @(posedge clk) begin
            if (wr.word_we[w]) begin
                mem[wr.index] <= wr.line[w];
            end
        end

        // read before write on an address clash
        always_ff @(posedge clk) begin
            if (rd_en) begin
                q[w] <= mem[rd_index];
            end
        end
    end

endmodule

`default_nettype wire

//--- source/l2_read_select.sv
/*
  Output stage of the L2 data array.
  Way number and offset arrive already delayed to match bank q.
  rd_line and rd_word hold their last value while rd_valid is low.
  There is no back-pressure. Results must be taken when valid.
*/
`default_nettype none

`include "l2_cache_defines.svh"

module l2_read_select (
    input  wire                                         clk,
    input  wire                                         rst_n,
    input  wire l2_cache_pkg::l2_line_t [`L2_WAYS-1:0]  way_q,
    input  wire                                         rd_pending,
    input  wire l2_cache_pkg::way_num_t                 rd_way_q,
    input  wire l2_cache_pkg::word_sel_t                rd_offset_q,
    output logic                                        rd_valid,
    output l2_cache_pkg::l2_line_t                      rd_line,
    output l2_cache_pkg::l2_word_t                      rd_word
);
    import l2_cache_pkg::*;

    l2_line_t sel_line;                    // addressed way's line
    l2_word_t sel_word;

    assign sel_line = way_q[rd_way_q];
    assign sel_word = sel_line[rd_offset_q];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_pending;        // one pulse per read
        end
    end

    // outputs start at zero after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_line <= '0;
            rd_word <= '0;
        end else if (rd_pending) begin
            rd_line <= sel_line;
            rd_word <= sel_word;
        end
    end

endmodule

`default_nettype wire

//--- source/l2_data_ram.sv
/*
  Data array of a four-way L2 cache, top level.
  Tags, hit detection and replacement live outside.
  Writes land at the edge that samples wr_req.
  rd_valid pulses two cycles after rd_req.rd_en, one read per cycle.
  Array contents are not reset.
*/
`default_nettype none

`include "l2_cache_defines.svh"

module l2_data_ram (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire l2_cache_pkg::l2_wr_req_t   wr_req,
    input  wire l2_cache_pkg::l2_rd_req_t   rd_req,
    output logic                            rd_valid,
    output l2_cache_pkg::l2_line_t          rd_line,
    output l2_cache_pkg::l2_word_t          rd_word
);
    l2_cache_pkg::way_wr_t [`L2_WAYS-1:0]   way_wr;     // per bank write command
    l2_cache_pkg::way_mask_t                rd_way_en;
    l2_cache_pkg::l2_index_t                rd_index;
    logic                                   rd_pending;
    l2_cache_pkg::way_num_t                 rd_way_q;
    l2_cache_pkg::word_sel_t                rd_offset_q;
    l2_cache_pkg::l2_line_t [`L2_WAYS-1:0]  way_q;      // bank read data

    l2_write_steer u_steer (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_req      (wr_req),
        .rd_req      (rd_req),
        .way_wr      (way_wr),
        .rd_way_en   (rd_way_en),
        .rd_index    (rd_index),
        .rd_pending  (rd_pending),
        .rd_way_q    (rd_way_q),
        .rd_offset_q (rd_offset_q)
    );

    for (genvar w = 0; w < `L2_WAYS; w++) begin : g_way
        l2_data_way u_way (
            .clk      (clk),
            .wr       (way_wr[w]),
            .rd_en    (rd_way_en[w]),
            .rd_index (rd_index),
            .q        (way_q[w])
        );
    end

    l2_read_select u_rd_sel (
        .clk         (clk),
        .rst_n       (rst_n),
        .way_q       (way_q),
        .rd_pending  (rd_pending),
        .rd_way_q    (rd_way_q),
        .rd_offset_q (rd_offset_q),
        .rd_valid    (rd_valid),
        .rd_line     (rd_line),
        .rd_word     (rd_word)
    );

endmodule

`default_nettype wire

//--- tb/l2_data_ram_tb.sv
/*
  Directed testbench for the L2 data array.
  A reference model of all ways and sets runs next to the DUT.
  The array is not reset, so only locations a test has written are read back.
  Outputs are sampled on the falling clock edge.
  The run stops at the first mismatch or timeout.
*/
`default_nettype none

`include "l2_cache_defines.svh"

module l2_data_ram_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import l2_cache_pkg::*;

    localparam int CLK_HALF = 20;
    localparam int MAX_WAIT = 20;          // cycles before a wait gives up

    logic        clk;
    logic        rst_n;
    l2_wr_req_t  wr_req;
    l2_rd_req_t  rd_req;
    logic        rd_valid;
    l2_line_t    rd_line;
    l2_word_t    rd_word;
    l2_index_t   idx_a;
    l2_index_t   idx_b;

    l2_line_t    model [`L2_WAYS][`L2_SETS];   // expected array contents

    l2_data_ram dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_req   (wr_req),
        .rd_req   (rd_req),
        .rd_valid (rd_valid),
        .rd_line  (rd_line),
        .rd_word  (rd_word)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    task automatic abort_run(string what);
        $display("ERROR: %s", what);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic compare(string test, logic [511:0] expected, logic [511:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected %h actual %h", test, expected, actual);
            $display("Simulation failed");
            $fatal(1, "run stopped");
        end
    endtask

    function automatic l2_line_t random_line();
        logic [511:0] bits;
        for (int i = 0; i < 16; i++) begin
            bits[i*32 +: 32] = $urandom();
        end
        return l2_line_t'(bits);
    endfunction

    function automatic l2_word_t random_word();
        l2_word_t word;
        for (int i = 0; i < 4; i++) begin
            word[i*32 +: 32] = $urandom();
        end
        return word;
    endfunction

    function automatic l2_wr_req_t fill_req(l2_index_t idx, way_mask_t ways, l2_line_t line);
        l2_wr_req_t req;
        req           = '0;
        req.index     = idx;
        req.way_we    = ways;
        req.fill_en   = 1'b1;
        req.fill_line = line;
        return req;
    endfunction

    function automatic l2_wr_req_t l1_req(l2_index_t idx, way_mask_t ways, word_sel_t off,
                                          l2_word_t word);
        l2_wr_req_t req;
        req          = '0;
        req.index    = idx;
        req.way_we   = ways;
        req.l1_wr_en = 1'b1;
        req.offset   = off;
        req.l1_word  = word;
        return req;
    endfunction

    function automatic l2_rd_req_t read_req(l2_index_t idx, way_num_t way, word_sel_t off);
        l2_rd_req_t req;
        req.rd_en  = 1'b1;
        req.index  = idx;
        req.way    = way;
        req.offset = off;
        return req;
    endfunction

    // fill wins over L1 and an L1 word lands only in the lowest enabled way
    function automatic void model_write(l2_wr_req_t req);
        if (req.fill_en) begin
            for (int w = 0; w < `L2_WAYS; w++) begin
                if (req.way_we[w]) model[w][req.index] = req.fill_line;
            end
        end else if (req.l1_wr_en) begin
            for (int w = 0; w < `L2_WAYS; w++) begin
                if (req.way_we[w]) begin
                    model[w][req.index][req.offset] = req.l1_word;
                    break;
                end
            end
        end
    endfunction

    task automatic drive_write(l2_wr_req_t req);
        @(posedge clk);
        wr_req <= req;
        model_write(req);
        @(posedge clk);
        wr_req <= '0;
    endtask

    task automatic read_and_check(string test, int way, l2_index_t idx, int off);
        int waited;
        @(posedge clk);
        rd_req <= read_req(idx, way_num_t'(way), word_sel_t'(off));
        @(posedge clk);
        rd_req <= '0;
        waited = 0;
        @(negedge clk);
        while (!rd_valid) begin
            waited++;
            if (waited > MAX_WAIT) abort_run({test, ": rd_valid never came after a read"});
            @(negedge clk);
        end
        compare(test, model[way][idx], rd_line);
        compare(test, model[way][idx][off], rd_word);
    endtask

    task automatic reset_stays_idle();
        repeat (5) begin
            @(negedge clk);
            compare("reset_stays_idle", 0, rd_valid);
            compare("reset_stays_idle", 0, rd_line);
            compare("reset_stays_idle", 0, rd_word);
        end
    endtask

    task automatic fill_two_ways(l2_index_t idx);
        drive_write(fill_req(idx, 4'b1111, random_line()));   // known background
        drive_write(fill_req(idx, 4'b0101, random_line()));
        for (int w = 0; w < `L2_WAYS; w++) begin
            for (int o = 0; o < `L2_WORDS; o++) read_and_check("fill_two_ways", w, idx, o);
        end
    endtask

    task automatic l1_single_word(l2_index_t idx);
        drive_write(l1_req(idx, 4'b0010, 2'd2, random_word()));
        for (int o = 0; o < `L2_WORDS; o++) read_and_check("l1_single_word", 1, idx, o);
    endtask

    task automatic l1_lowest_way(l2_index_t idx);
        drive_write(l1_req(idx, 4'b1100, 2'd1, random_word()));  // only way 2
        for (int w = 0; w < `L2_WAYS; w++) read_and_check("l1_lowest_way", w, idx, 1);
    endtask

    task automatic fill_beats_l1(l2_index_t idx);
        l2_wr_req_t req;
        req          = fill_req(idx, 4'b0011, random_line());
        req.l1_wr_en = 1'b1;
        req.offset   = 2'd3;
        req.l1_word  = random_word();
        drive_write(req);
        for (int w = 0; w < `L2_WAYS; w++) read_and_check("fill_beats_l1", w, idx, 3);
    endtask

    // four reads on consecutive cycles with the last one hit by a write
    task automatic back_to_back_reads(l2_index_t ia, l2_index_t ib);
        int         ways [4] = '{0, 3, 1, 2};
        int         offs [4] = '{0, 1, 3, 2};
        l2_index_t  idxs [4];
        l2_line_t   line_q [$];
        int         off_q [$];
        int         due_q [$];
        l2_wr_req_t clash;
        int         cyc;
        int         off;
        idxs  = '{ia, ib, ia, ib};
        drive_write(fill_req(ib, 4'b1111, random_line()));
        clash = fill_req(ib, 4'b0100, random_line());
        cyc   = 0;
        while (cyc < 4 || due_q.size() > 0) begin
            @(posedge clk);
            if (cyc < 4) begin
                rd_req <= read_req(idxs[cyc], way_num_t'(ways[cyc]), word_sel_t'(offs[cyc]));
                line_q.push_back(model[ways[cyc]][idxs[cyc]]);
                off_q.push_back(offs[cyc]);
                due_q.push_back(cyc + 2);
                if (cyc == 3) begin
                    wr_req <= clash;           // same way and index as this read
                    model_write(clash);
                end
            end else begin
                rd_req <= '0;
                wr_req <= '0;
            end
            @(negedge clk);
            if (rd_valid) begin
                if (due_q.size() == 0) abort_run("back_to_back_reads: extra rd_valid pulse");
                compare("back_to_back_reads", due_q.pop_front(), cyc);
                off = off_q.pop_front();
                compare("back_to_back_reads", line_q[0][off], rd_word);
                compare("back_to_back_reads", line_q.pop_front(), rd_line);
            end else if (due_q.size() > 0 && cyc >= due_q[0]) begin
                abort_run("back_to_back_reads: rd_valid never came for a read");
            end
            cyc++;
            if (cyc > MAX_WAIT) abort_run("back_to_back_reads: reads did not drain");
        end
        read_and_check("back_to_back_reads", 2, ib, 0);   // new data now visible
    endtask

    initial begin
        void'($urandom(32'h8fb3e499));
        rst_n  = 1'b0;
        wr_req = '0;
        rd_req = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        idx_a = l2_index_t'($urandom());
        idx_b = idx_a ^ 9'h100;            // a different set

        reset_stays_idle();
        fill_two_ways(idx_a);
        l1_single_word(idx_a);
        l1_lowest_way(idx_a);
        fill_beats_l1(idx_a);
        back_to_back_reads(idx_a, idx_b);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- l2_data.f
+incdir+source
source/l2_cache_pkg.sv
source/l2_write_steer.sv
source/l2_data_way.sv
source/l2_read_select.sv
source/l2_data_ram.sv
tb/l2_data_ram_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the L2 data array testbench with Verilator and run it.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    -f l2_data.f --top-module l2_data_ram_tb -o l2_data_sim

# a failing run still leaves its log for the search below
./obj_dir/l2_data_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation completed successfully$" sim.log; then
    echo "RESULT: PASS"
else
    echo "RESULT: FAIL"
    exit 1
fi
